// File: src/dualIssuePkg.sv
/* Shared widths, word types and control encodings for the two-lane datapath.
   Every lane module and the register file refer to these by scoped name */
package dualIssuePkg;

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam int NumRegs      = 32;

    typedef logic [DataWidth-1:0]    word_t;
    typedef logic [31:0]             instr_t;
    typedef logic [RegAddrWidth-1:0] regAddr_t;

    // addi x0, x0, 0
    localparam instr_t NopInstr = 32'h0000_0013;

    // Immediate layout selected in decode
    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_U = 2'b10
    } immSrc_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_XOR = 3'b100,
        ALU_SLT = 3'b101
    } aluOp_t;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_RF  = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } forwardSel_t;

    // Value written back to the register file
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_IMM = 2'b10
    } resultSrc_t;

endpackage

// File: src/laneDecode.sv
/* Decode stage of one lane. Captures the instruction with its controls,
   splits out the register fields and builds the I, S or U immediate */
`timescale 1ns/1ps

module laneDecode #(
    parameter dualIssuePkg::instr_t ResetInstr = dualIssuePkg::NopInstr
) (
    input  logic                     clk,
    input  logic                     reset,
    input  dualIssuePkg::instr_t     instr_i,
    input  logic                     stall_i,
    input  logic                     flush_i,
    input  dualIssuePkg::immSrc_t    immSrc_i,
    input  logic                     aluSrc_i,
    input  dualIssuePkg::aluOp_t     aluOp_i,
    input  dualIssuePkg::resultSrc_t resultSrc_i,
    input  logic                     regWrite_i,
    output dualIssuePkg::regAddr_t   rs1_o,
    output dualIssuePkg::regAddr_t   rs2_o,
    output dualIssuePkg::regAddr_t   rd_o,
    output dualIssuePkg::word_t      imm_o,
    output logic                     aluSrc_o,
    output dualIssuePkg::aluOp_t     aluOp_o,
    output dualIssuePkg::resultSrc_t resultSrc_o,
    output logic                     regWrite_o
);

    dualIssuePkg::instr_t  instrD;
    dualIssuePkg::immSrc_t immSrcD;

    // Flush turns the slot into a bubble that never writes back
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            instrD      <= ResetInstr;
            immSrcD     <= dualIssuePkg::IMM_I;
            aluSrc_o    <= 1'b0;
            aluOp_o     <= dualIssuePkg::ALU_ADD;
            resultSrc_o <= dualIssuePkg::RES_ALU;
            regWrite_o  <= 1'b0;
        end else if (!stall_i) begin
            instrD      <= instr_i;
            immSrcD     <= immSrc_i;
            aluSrc_o    <= aluSrc_i;
            aluOp_o     <= aluOp_i;
            resultSrc_o <= resultSrc_i;
            regWrite_o  <= regWrite_i;
        end
    end

    assign rs1_o = instrD[19:15];
    assign rs2_o = instrD[24:20];
    assign rd_o  = instrD[11:7];

    // Sign bit is always instr[31]
    always_comb begin
        case (immSrcD)
            dualIssuePkg::IMM_I: imm_o = {{20{instrD[31]}}, instrD[31:20]};
            dualIssuePkg::IMM_S: imm_o = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            dualIssuePkg::IMM_U: imm_o = {instrD[31:12], 12'b0};
            default:             imm_o = '0;
        endcase
    end

endmodule

// File: src/laneExecute.sv
/* Execute stage of one lane. Registers the decoded operands, picks forwarded
   values from the lane's own M and W stages and runs the ALU */
`timescale 1ns/1ps

module laneExecute (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush_i,
    input  logic                      stallD_i,
    input  dualIssuePkg::word_t       rs1Data_i,
    input  dualIssuePkg::word_t       rs2Data_i,
    input  dualIssuePkg::word_t       imm_i,
    input  dualIssuePkg::regAddr_t    rd_i,
    input  logic                      aluSrc_i,
    input  dualIssuePkg::aluOp_t      aluOp_i,
    input  dualIssuePkg::resultSrc_t  resultSrc_i,
    input  logic                      regWrite_i,
    input  dualIssuePkg::forwardSel_t forwardA_i,
    input  dualIssuePkg::forwardSel_t forwardB_i,
    input  dualIssuePkg::word_t       fwdMem_i,
    input  dualIssuePkg::word_t       fwdWb_i,
    output dualIssuePkg::word_t       aluResult_o,
    output dualIssuePkg::word_t       writeData_o,
    output dualIssuePkg::word_t       immE_o,
    output dualIssuePkg::regAddr_t    rdE_o,
    output dualIssuePkg::resultSrc_t  resultSrcE_o,
    output logic                      regWriteE_o,
    output logic                      zero_o
);

    dualIssuePkg::word_t  rs1DataE;
    dualIssuePkg::word_t  rs2DataE;
    dualIssuePkg::word_t  srcA;
    dualIssuePkg::word_t  srcB;
    logic                 aluSrcE;
    dualIssuePkg::aluOp_t aluOpE;

    // A stalled decode stays put, so execute sees a bubble instead of a copy
    always_ff @(posedge clk) begin
        if (reset || flush_i || stallD_i) begin
            aluSrcE      <= 1'b0;
            aluOpE       <= dualIssuePkg::ALU_ADD;
            resultSrcE_o <= dualIssuePkg::RES_ALU;
            regWriteE_o  <= 1'b0;
        end else begin
            aluSrcE      <= aluSrc_i;
            aluOpE       <= aluOp_i;
            resultSrcE_o <= resultSrc_i;
            regWriteE_o  <= regWrite_i;
        end
    end

    always_ff @(posedge clk) begin
        rs1DataE <= rs1Data_i;
        rs2DataE <= rs2Data_i;
        immE_o   <= imm_i;
        rdE_o    <= rd_i;
    end

    always_comb begin
        case (forwardA_i)
            dualIssuePkg::FWD_MEM: srcA = fwdMem_i;
            dualIssuePkg::FWD_WB:  srcA = fwdWb_i;
            default:               srcA = rs1DataE;
        endcase
    end

    // Forwarded B doubles as store data
    always_comb begin
        case (forwardB_i)
            dualIssuePkg::FWD_MEM: writeData_o = fwdMem_i;
            dualIssuePkg::FWD_WB:  writeData_o = fwdWb_i;
            default:               writeData_o = rs2DataE;
        endcase
    end

    assign srcB = aluSrcE ? immE_o : writeData_o;

    always_comb begin
        case (aluOpE)
            dualIssuePkg::ALU_ADD: aluResult_o = srcA + srcB;
            dualIssuePkg::ALU_SUB: aluResult_o = srcA - srcB;
            dualIssuePkg::ALU_AND: aluResult_o = srcA & srcB;
            dualIssuePkg::ALU_OR:  aluResult_o = srcA | srcB;
            dualIssuePkg::ALU_XOR: aluResult_o = srcA ^ srcB;
            dualIssuePkg::ALU_SLT:
                aluResult_o = dualIssuePkg::word_t'($signed(srcA) < $signed(srcB));
            default:               aluResult_o = '0;
        endcase
    end

    // Zero flag for beq/bne style checks
    assign zero_o = (aluResult_o == '0);

endmodule

// File: src/laneRetire.sv
/* Memory and writeback stages of one lane. Provides the M-stage forward value
   and the final writeback result and register write port */
`timescale 1ns/1ps

module laneRetire (
    input  logic                     clk,
    input  logic                     reset,
    input  dualIssuePkg::word_t      aluResult_i,
    input  dualIssuePkg::word_t      writeData_i,
    input  dualIssuePkg::word_t      imm_i,
    input  dualIssuePkg::regAddr_t   rd_i,
    input  dualIssuePkg::resultSrc_t resultSrc_i,
    input  logic                     regWrite_i,
    input  dualIssuePkg::word_t      readData_i,
    output dualIssuePkg::word_t      aluResultM_o,
    output dualIssuePkg::word_t      writeDataM_o,
    output dualIssuePkg::word_t      fwdMem_o,
    output dualIssuePkg::word_t      resultW_o,
    output dualIssuePkg::regAddr_t   rdM_o,
    output dualIssuePkg::regAddr_t   rdW_o,
    output logic                     regWriteW_o
);

    dualIssuePkg::word_t      immM;
    dualIssuePkg::resultSrc_t resultSrcM;
    logic                     regWriteM;
    dualIssuePkg::word_t      aluResultW;
    dualIssuePkg::word_t      readDataW;
    dualIssuePkg::word_t      immW;
    dualIssuePkg::resultSrc_t resultSrcW;

    always_ff @(posedge clk) begin
        if (reset) begin
            resultSrcM  <= dualIssuePkg::RES_ALU;
            regWriteM   <= 1'b0;
            resultSrcW  <= dualIssuePkg::RES_ALU;
            regWriteW_o <= 1'b0;
        end else begin
            resultSrcM  <= resultSrc_i;
            regWriteM   <= regWrite_i;
            resultSrcW  <= resultSrcM;
            regWriteW_o <= regWriteM;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM_o <= aluResult_i;
        writeDataM_o <= writeData_i;
        immM         <= imm_i;
        rdM_o        <= rd_i;
        aluResultW   <= aluResultM_o;
        readDataW    <= readData_i;
        immW         <= immM;
        rdW_o        <= rdM_o;
    end

    // Load data is not back yet in M, so only ALU or immediate can forward
    assign fwdMem_o = (resultSrcM == dualIssuePkg::RES_IMM) ? immM : aluResultM_o;

    always_comb begin
        case (resultSrcW)
            dualIssuePkg::RES_MEM: resultW_o = readDataW;
            dualIssuePkg::RES_IMM: resultW_o = immW;
            default:               resultW_o = aluResultW;
        endcase
    end

endmodule

// File: src/regFile.sv
/* Shared register file for both lanes. Four read ports and two write ports,
   lane 2 is younger and wins a same-register write, reads see same-cycle writes */
`timescale 1ns/1ps

module regFile (
    input  logic                   clk,
    input  logic                   reset,
    input  dualIssuePkg::regAddr_t raddr1A_i,
    input  dualIssuePkg::regAddr_t raddr1B_i,
    input  dualIssuePkg::regAddr_t raddr2A_i,
    input  dualIssuePkg::regAddr_t raddr2B_i,
    output dualIssuePkg::word_t    rdata1A_o,
    output dualIssuePkg::word_t    rdata1B_o,
    output dualIssuePkg::word_t    rdata2A_o,
    output dualIssuePkg::word_t    rdata2B_o,
    input  logic                   we1_i,
    input  dualIssuePkg::regAddr_t waddr1_i,
    input  dualIssuePkg::word_t    wdata1_i,
    input  logic                   we2_i,
    input  dualIssuePkg::regAddr_t waddr2_i,
    input  dualIssuePkg::word_t    wdata2_i
);

    // x0 has no storage
    dualIssuePkg::word_t regs [1:dualIssuePkg::NumRegs-1];

    // Same priority as the write merge below
    function automatic dualIssuePkg::word_t readPort(input dualIssuePkg::regAddr_t addr);
        if (addr == '0)
            return '0;
        else if (we2_i && waddr2_i == addr)
            return wdata2_i;
        else if (we1_i && waddr1_i == addr)
            return wdata1_i;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < dualIssuePkg::NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we1_i && waddr1_i != '0)
                regs[waddr1_i] <= wdata1_i;
            // Later assignment overrides lane 1 on a shared rd
            if (we2_i && waddr2_i != '0)
                regs[waddr2_i] <= wdata2_i;
        end
    end

    always_comb begin
        rdata1A_o = readPort(raddr1A_i);
        rdata1B_o = readPort(raddr1B_i);
        rdata2A_o = readPort(raddr2A_i);
        rdata2B_o = readPort(raddr2B_i);
    end

endmodule

// File: src/dualIssueDatapath.sv
/* Two-lane execution datapath. Each lane runs decode, execute and retire
   side by side, and the shared register file joins their reads and writes */
`timescale 1ns/1ps

module dualIssueDatapath #(
    parameter dualIssuePkg::instr_t ResetInstr = dualIssuePkg::NopInstr
) (
    input  logic                      clk,
    input  logic                      reset,
    // Decode cycle
    input  dualIssuePkg::instr_t      instr1_i,
    input  dualIssuePkg::instr_t      instr2_i,
    input  dualIssuePkg::immSrc_t     immSrc1_i,
    input  dualIssuePkg::immSrc_t     immSrc2_i,
    input  logic                      aluSrc1_i,
    input  logic                      aluSrc2_i,
    input  dualIssuePkg::aluOp_t      aluOp1_i,
    input  dualIssuePkg::aluOp_t      aluOp2_i,
    input  dualIssuePkg::resultSrc_t  resultSrc1_i,
    input  dualIssuePkg::resultSrc_t  resultSrc2_i,
    input  logic                      regWrite1_i,
    input  logic                      regWrite2_i,
    input  logic                      stallD1_i,
    input  logic                      stallD2_i,
    input  logic                      flushD1_i,
    input  logic                      flushD2_i,
    // Execute cycle
    input  dualIssuePkg::forwardSel_t forwardA1_i,
    input  dualIssuePkg::forwardSel_t forwardA2_i,
    input  dualIssuePkg::forwardSel_t forwardB1_i,
    input  dualIssuePkg::forwardSel_t forwardB2_i,
    input  logic                      flushE1_i,
    input  logic                      flushE2_i,
    // Memory cycle
    input  dualIssuePkg::word_t       readDataM1_i,
    input  dualIssuePkg::word_t       readDataM2_i,
    output logic                      zeroE1_o,
    output logic                      zeroE2_o,
    output dualIssuePkg::word_t       aluResultM1_o,
    output dualIssuePkg::word_t       aluResultM2_o,
    output dualIssuePkg::word_t       writeDataM1_o,
    output dualIssuePkg::word_t       writeDataM2_o,
    output dualIssuePkg::regAddr_t    rdM1_o,
    output dualIssuePkg::regAddr_t    rdM2_o,
    output dualIssuePkg::word_t       resultW1_o,
    output dualIssuePkg::word_t       resultW2_o,
    output dualIssuePkg::regAddr_t    rdW1_o,
    output dualIssuePkg::regAddr_t    rdW2_o,
    output logic                      regWriteW1_o,
    output logic                      regWriteW2_o
);

    dualIssuePkg::regAddr_t   rs1D1, rs2D1, rdD1, rdE1;
    dualIssuePkg::regAddr_t   rs1D2, rs2D2, rdD2, rdE2;
    dualIssuePkg::word_t      immD1, rs1Data1, rs2Data1, aluResultE1, writeDataE1, immE1;
    dualIssuePkg::word_t      immD2, rs1Data2, rs2Data2, aluResultE2, writeDataE2, immE2;
    dualIssuePkg::word_t      fwdMem1, fwdMem2;
    dualIssuePkg::aluOp_t     aluOpD1, aluOpD2;
    dualIssuePkg::resultSrc_t resultSrcD1, resultSrcD2, resultSrcE1, resultSrcE2;
    logic                     aluSrcD1, aluSrcD2;
    logic                     regWriteD1, regWriteD2, regWriteE1, regWriteE2;

    // Lane 1, older in program order
    laneDecode #(.ResetInstr(ResetInstr)) i_decode1 (
        .clk(clk), .reset(reset), .instr_i(instr1_i),
        .stall_i(stallD1_i), .flush_i(flushD1_i),
        .immSrc_i(immSrc1_i), .aluSrc_i(aluSrc1_i), .aluOp_i(aluOp1_i),
        .resultSrc_i(resultSrc1_i), .regWrite_i(regWrite1_i),
        .rs1_o(rs1D1), .rs2_o(rs2D1), .rd_o(rdD1), .imm_o(immD1),
        .aluSrc_o(aluSrcD1), .aluOp_o(aluOpD1),
        .resultSrc_o(resultSrcD1), .regWrite_o(regWriteD1)
    );

    laneExecute i_execute1 (
        .clk(clk), .reset(reset), .flush_i(flushE1_i), .stallD_i(stallD1_i),
        .rs1Data_i(rs1Data1), .rs2Data_i(rs2Data1), .imm_i(immD1), .rd_i(rdD1),
        .aluSrc_i(aluSrcD1), .aluOp_i(aluOpD1),
        .resultSrc_i(resultSrcD1), .regWrite_i(regWriteD1),
        .forwardA_i(forwardA1_i), .forwardB_i(forwardB1_i),
        .fwdMem_i(fwdMem1), .fwdWb_i(resultW1_o),
        .aluResult_o(aluResultE1), .writeData_o(writeDataE1), .immE_o(immE1),
        .rdE_o(rdE1), .resultSrcE_o(resultSrcE1), .regWriteE_o(regWriteE1),
        .zero_o(zeroE1_o)
    );

    laneRetire i_retire1 (
        .clk(clk), .reset(reset),
        .aluResult_i(aluResultE1), .writeData_i(writeDataE1), .imm_i(immE1),
        .rd_i(rdE1), .resultSrc_i(resultSrcE1), .regWrite_i(regWriteE1),
        .readData_i(readDataM1_i),
        .aluResultM_o(aluResultM1_o), .writeDataM_o(writeDataM1_o),
        .fwdMem_o(fwdMem1), .resultW_o(resultW1_o),
        .rdM_o(rdM1_o), .rdW_o(rdW1_o), .regWriteW_o(regWriteW1_o)
    );

    // Lane 2, younger in program order
    laneDecode #(.ResetInstr(ResetInstr)) i_decode2 (
        .clk(clk), .reset(reset), .instr_i(instr2_i),
        .stall_i(stallD2_i), .flush_i(flushD2_i),
        .immSrc_i(immSrc2_i), .aluSrc_i(aluSrc2_i), .aluOp_i(aluOp2_i),
        .resultSrc_i(resultSrc2_i), .regWrite_i(regWrite2_i),
        .rs1_o(rs1D2), .rs2_o(rs2D2), .rd_o(rdD2), .imm_o(immD2),
        .aluSrc_o(aluSrcD2), .aluOp_o(aluOpD2),
        .resultSrc_o(resultSrcD2), .regWrite_o(regWriteD2)
    );

    laneExecute i_execute2 (
        .clk(clk), .reset(reset), .flush_i(flushE2_i), .stallD_i(stallD2_i),
        .rs1Data_i(rs1Data2), .rs2Data_i(rs2Data2), .imm_i(immD2), .rd_i(rdD2),
        .aluSrc_i(aluSrcD2), .aluOp_i(aluOpD2),
        .resultSrc_i(resultSrcD2), .regWrite_i(regWriteD2),
        .forwardA_i(forwardA2_i), .forwardB_i(forwardB2_i),
        .fwdMem_i(fwdMem2), .fwdWb_i(resultW2_o),
        .aluResult_o(aluResultE2), .writeData_o(writeDataE2), .immE_o(immE2),
        .rdE_o(rdE2), .resultSrcE_o(resultSrcE2), .regWriteE_o(regWriteE2),
        .zero_o(zeroE2_o)
    );

    laneRetire i_retire2 (
        .clk(clk), .reset(reset),
        .aluResult_i(aluResultE2), .writeData_i(writeDataE2), .imm_i(immE2),
        .rd_i(rdE2), .resultSrc_i(resultSrcE2), .regWrite_i(regWriteE2),
        .readData_i(readDataM2_i),
        .aluResultM_o(aluResultM2_o), .writeDataM_o(writeDataM2_o),
        .fwdMem_o(fwdMem2), .resultW_o(resultW2_o),
        .rdM_o(rdM2_o), .rdW_o(rdW2_o), .regWriteW_o(regWriteW2_o)
    );

    // Write port 2 belongs to the younger lane
    regFile i_regFile (
        .clk(clk), .reset(reset),
        .raddr1A_i(rs1D1), .raddr1B_i(rs2D1), .raddr2A_i(rs1D2), .raddr2B_i(rs2D2),
        .rdata1A_o(rs1Data1), .rdata1B_o(rs2Data1),
        .rdata2A_o(rs1Data2), .rdata2B_o(rs2Data2),
        .we1_i(regWriteW1_o), .waddr1_i(rdW1_o), .wdata1_i(resultW1_o),
        .we2_i(regWriteW2_o), .waddr2_i(rdW2_o), .wdata2_i(resultW2_o)
    );

endmodule

// File: dv/tbDualIssue.sv
/* Table-driven testbench for the two-lane datapath. A reference register model
   predicts writebacks, zero flags and store data, which are checked as they appear */
`timescale 1ns/1ps

module tbDualIssue;

    localparam int NumRows = 20;
    localparam int MaxCyc  = NumRows + 16;
    localparam int KindR   = 0;
    localparam int KindI   = 1;
    localparam int KindL   = 2;
    localparam int KindS   = 3;
    localparam int KindU   = 4;

    typedef struct {
        int          kind;
        int          op;
        int          rd;
        int          rs1;
        int          rs2;
        logic [31:0] imm;
        int          fa;
        int          fb;
        bit          fd;
        bit          fe;
        bit          st;
    } slot_t;

    logic clk;
    logic reset;
    dualIssuePkg::instr_t      instr [1:2];
    dualIssuePkg::immSrc_t     immSrc [1:2];
    logic                      aluSrc [1:2];
    dualIssuePkg::aluOp_t      aluOp [1:2];
    dualIssuePkg::resultSrc_t  resultSrc [1:2];
    logic                      regWrite [1:2];
    logic                      stallD [1:2];
    logic                      flushD [1:2];
    dualIssuePkg::forwardSel_t forwardA [1:2];
    dualIssuePkg::forwardSel_t forwardB [1:2];
    logic                      flushE [1:2];
    dualIssuePkg::word_t       readDataM [1:2];
    logic                      zeroE [1:2];
    dualIssuePkg::word_t       aluResultM [1:2];
    dualIssuePkg::word_t       writeDataM [1:2];
    dualIssuePkg::regAddr_t    rdM [1:2];
    dualIssuePkg::word_t       resultW [1:2];
    dualIssuePkg::regAddr_t    rdW [1:2];
    logic                      regWriteW [1:2];

    slot_t       tbl [1:2][0:NumRows-1];
    logic [31:0] refRegs [0:31];
    logic [36:0] wbQ [1:2][$];
    bit          zeroValid [1:2][0:MaxCyc];
    logic        zeroExp [1:2][0:MaxCyc];
    bit          storeValid [1:2][0:MaxCyc];
    logic [31:0] storeExp [1:2][0:MaxCyc];
    bit          rdMValid [1:2][0:MaxCyc];
    logic [4:0]  rdMExp [1:2][0:MaxCyc];
    bit          aluMValid [1:2][0:MaxCyc];
    logic [31:0] aluMExp [1:2][0:MaxCyc];
    int          cycleNo = 0;
    int          errors = 0;
    int          checks = 0;
    int          seed = 32'h70ee;

    dualIssueDatapath i_dut (
        .clk(clk), .reset(reset),
        .instr1_i(instr[1]), .instr2_i(instr[2]),
        .immSrc1_i(immSrc[1]), .immSrc2_i(immSrc[2]),
        .aluSrc1_i(aluSrc[1]), .aluSrc2_i(aluSrc[2]),
        .aluOp1_i(aluOp[1]), .aluOp2_i(aluOp[2]),
        .resultSrc1_i(resultSrc[1]), .resultSrc2_i(resultSrc[2]),
        .regWrite1_i(regWrite[1]), .regWrite2_i(regWrite[2]),
        .stallD1_i(stallD[1]), .stallD2_i(stallD[2]),
        .flushD1_i(flushD[1]), .flushD2_i(flushD[2]),
        .forwardA1_i(forwardA[1]), .forwardA2_i(forwardA[2]),
        .forwardB1_i(forwardB[1]), .forwardB2_i(forwardB[2]),
        .flushE1_i(flushE[1]), .flushE2_i(flushE[2]),
        .readDataM1_i(readDataM[1]), .readDataM2_i(readDataM[2]),
        .zeroE1_o(zeroE[1]), .zeroE2_o(zeroE[2]),
        .aluResultM1_o(aluResultM[1]), .aluResultM2_o(aluResultM[2]),
        .writeDataM1_o(writeDataM[1]), .writeDataM2_o(writeDataM[2]),
        .rdM1_o(rdM[1]), .rdM2_o(rdM[2]),
        .resultW1_o(resultW[1]), .resultW2_o(resultW[2]),
        .rdW1_o(rdW[1]), .rdW2_o(rdW[2]),
        .regWriteW1_o(regWriteW[1]), .regWriteW2_o(regWriteW[2])
    );

    // Data memory stand-in, a fixed function of the address
    function automatic logic [31:0] memData(input logic [31:0] addr);
        return {addr[15:0] ^ 16'hc3a5, addr[31:16]};
    endfunction

    assign readDataM[1] = memData(aluResultM[1]);
    assign readDataM[2] = memData(aluResultM[2]);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleNo <= cycleNo + 1;
    end

    function automatic logic [31:0] aluModel(input int op, input logic [31:0] a,
                                             input logic [31:0] b);
        case (op)
            dualIssuePkg::ALU_SUB: return a - b;
            dualIssuePkg::ALU_AND: return a & b;
            dualIssuePkg::ALU_OR:  return a | b;
            dualIssuePkg::ALU_XOR: return a ^ b;
            dualIssuePkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:               return a + b;
        endcase
    endfunction

    task automatic setSlot(input int ln, input int r, input int kind, input int op,
                           input int rd, input int rs1, input int rs2,
                           input logic [31:0] imm, input int fa, input int fb);
        tbl[ln][r] = '{kind, op, rd, rs1, rs2, imm, fa, fb, 1'b0, 1'b0, 1'b0};
    endtask

    // Drives row r of one lane with the execute flush of row r-1 and the forwards
    // of row r-2, which is in execute while row r is on the inputs
    task automatic driveRow(input int ln, input int r, input int rc);
        slot_t       s;
        logic [31:0] immX;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        int          eCyc;
        s = tbl[ln][r];
        immX = (s.kind == KindU) ? {s.imm[19:0], 12'b0} : {{20{s.imm[11]}}, s.imm[11:0]};
        case (s.kind)
            KindR: instr[ln] <= {7'b0, s.rs2[4:0], s.rs1[4:0], 3'b0, s.rd[4:0], 7'h33};
            KindS: instr[ln] <= {s.imm[11:5], s.rs2[4:0], s.rs1[4:0], 3'b010,
                                 s.imm[4:0], 7'h23};
            KindU: instr[ln] <= {s.imm[19:0], s.rd[4:0], 7'h37};
            default: instr[ln] <= {s.imm[11:0], s.rs1[4:0], 3'b0, s.rd[4:0], 7'h13};
        endcase
        immSrc[ln] <= (s.kind == KindS) ? dualIssuePkg::IMM_S :
                      (s.kind == KindU) ? dualIssuePkg::IMM_U : dualIssuePkg::IMM_I;
        aluSrc[ln] <= (s.kind != KindR);
        aluOp[ln] <= dualIssuePkg::aluOp_t'(s.op[2:0]);
        resultSrc[ln] <= (s.kind == KindL) ? dualIssuePkg::RES_MEM :
                         (s.kind == KindU) ? dualIssuePkg::RES_IMM : dualIssuePkg::RES_ALU;
        regWrite[ln] <= (s.kind != KindS);
        stallD[ln] <= s.st;
        flushD[ln] <= s.fd;
        forwardA[ln] <= (r > 1) ? dualIssuePkg::forwardSel_t'(tbl[ln][r-2].fa[1:0])
                                : dualIssuePkg::FWD_RF;
        forwardB[ln] <= (r > 1) ? dualIssuePkg::forwardSel_t'(tbl[ln][r-2].fb[1:0])
                                : dualIssuePkg::FWD_RF;
        flushE[ln] <= (r > 0) ? tbl[ln][r-1].fe : 1'b0;
        if (s.fd || s.fe || s.st) begin
            return;
        end
        a = refRegs[s.rs1];
        b = (s.kind == KindR) ? refRegs[s.rs2] : immX;
        res = aluModel(s.op, a, b);
        // A stall in the next row holds this one in decode for an extra cycle
        eCyc = rc + 2;
        if (r + 1 < NumRows && tbl[ln][r+1].st) begin
            eCyc = eCyc + 1;
        end
        if (s.kind == KindR || s.kind == KindI) begin
            zeroValid[ln][eCyc] = 1'b1;
            zeroExp[ln][eCyc] = (res == 32'd0);
        end
        // Store rd field carries imm[4:0]
        rdMValid[ln][eCyc+1] = 1'b1;
        rdMExp[ln][eCyc+1] = (s.kind == KindS) ? s.imm[4:0] : s.rd[4:0];
        if (s.kind != KindU) begin
            aluMValid[ln][eCyc+1] = 1'b1;
            aluMExp[ln][eCyc+1] = res;
        end
        if (s.kind == KindS) begin
            storeValid[ln][eCyc+1] = 1'b1;
            storeExp[ln][eCyc+1] = refRegs[s.rs2];
            return;
        end
        if (s.kind == KindL) begin
            res = memData(a + immX);
        end else if (s.kind == KindU) begin
            res = immX;
        end
        wbQ[ln].push_back({s.rd[4:0], res});
        if (s.rd != 0) begin
            refRegs[s.rd] = res;
        end
    endtask

    always @(negedge clk) begin
        logic [36:0] exp;
        for (int ln = 1; ln <= 2; ln++) begin
            if (regWriteW[ln] !== 1'b0) begin
                checks++;
                if (wbQ[ln].size() == 0) begin
                    errors++;
                    $display("[ERROR] %0t: lane %0d writes back x%0d with no instruction due",
                             $time, ln, rdW[ln]);
                end else begin
                    exp = wbQ[ln].pop_front();
                    if (rdW[ln] !== exp[36:32] || resultW[ln] !== exp[31:0]) begin
                        errors++;
                        $display("[ERROR] %0t: lane %0d wrote x%0d=%h, expected x%0d=%h",
                                 $time, ln, rdW[ln], resultW[ln], exp[36:32], exp[31:0]);
                    end
                end
            end
            if (cycleNo <= MaxCyc && zeroValid[ln][cycleNo]) begin
                checks++;
                if (zeroE[ln] !== zeroExp[ln][cycleNo]) begin
                    errors++;
                    $display("[ERROR] %0t: lane %0d zero flag %b, expected %b",
                             $time, ln, zeroE[ln], zeroExp[ln][cycleNo]);
                end
            end
            if (cycleNo <= MaxCyc && rdMValid[ln][cycleNo]) begin
                checks++;
                if (rdM[ln] !== rdMExp[ln][cycleNo]) begin
                    errors++;
                    $display("[ERROR] %0t: lane %0d rdM x%0d, expected x%0d",
                             $time, ln, rdM[ln], rdMExp[ln][cycleNo]);
                end
            end
            if (cycleNo <= MaxCyc && aluMValid[ln][cycleNo]) begin
                checks++;
                if (aluResultM[ln] !== aluMExp[ln][cycleNo]) begin
                    errors++;
                    $display("[ERROR] %0t: lane %0d aluResultM %h, expected %h",
                             $time, ln, aluResultM[ln], aluMExp[ln][cycleNo]);
                end
            end
            if (cycleNo <= MaxCyc && storeValid[ln][cycleNo]) begin
                checks++;
                if (writeDataM[ln] !== storeExp[ln][cycleNo]) begin
                    errors++;
                    $display("[ERROR] %0t: lane %0d store data %h, expected %h",
                             $time, ln, writeDataM[ln], storeExp[ln][cycleNo]);
                end
            end
        end
    end

    initial begin
        #((NumRows + 10) * 40);
        $display("Watchdog expired before all writebacks were seen");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        for (int ln = 1; ln <= 2; ln++) begin
            instr[ln] = dualIssuePkg::NopInstr;
            immSrc[ln] = dualIssuePkg::IMM_I;
            aluSrc[ln] = 1'b0;
            aluOp[ln] = dualIssuePkg::ALU_ADD;
            resultSrc[ln] = dualIssuePkg::RES_ALU;
            regWrite[ln] = 1'b0;
            stallD[ln] = 1'b0;
            flushD[ln] = 1'b0;
            forwardA[ln] = dualIssuePkg::FWD_RF;
            forwardB[ln] = dualIssuePkg::FWD_RF;
            flushE[ln] = 1'b0;
            for (int r = 0; r < NumRows; r++) begin
                tbl[ln][r] = '{KindI, 0, 0, 0, 0, 32'd0, 0, 0, 1'b1, 1'b0, 1'b0};
            end
        end
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = 32'd0;
        end
        // Lane 1 owns x1..x9, lane 2 owns x10..x20, x7 is shared on purpose
        setSlot(1, 0, KindI, dualIssuePkg::ALU_ADD, 1, 0, 0, $random(seed), 0, 0);
        setSlot(2, 0, KindU, dualIssuePkg::ALU_ADD, 10, 0, 0, 32'h12345, 0, 0);
        setSlot(1, 1, KindI, dualIssuePkg::ALU_ADD, 2, 0, 0, 32'd7, 0, 0);
        setSlot(2, 1, KindI, dualIssuePkg::ALU_ADD, 11, 0, 0, 32'hffd, 0, 0);
        setSlot(1, 2, KindR, dualIssuePkg::ALU_SUB, 3, 1, 1, 32'd0, 1, 1);
        setSlot(2, 2, KindR, dualIssuePkg::ALU_ADD, 12, 10, 11, 32'd0, 1, 2);
        setSlot(1, 3, KindR, dualIssuePkg::ALU_ADD, 4, 3, 2, 32'd0, 2, 1);
        setSlot(2, 3, KindR, dualIssuePkg::ALU_XOR, 13, 12, 10, 32'd0, 2, 0);
        setSlot(1, 4, KindR, dualIssuePkg::ALU_SLT, 5, 4, 3, 32'd0, 2, 1);
        setSlot(2, 4, KindI, dualIssuePkg::ALU_OR, 14, 13, 0, $random(seed), 2, 0);
        setSlot(1, 5, KindS, dualIssuePkg::ALU_ADD, 0, 2, 4, 32'd8, 0, 1);
        setSlot(2, 5, KindL, dualIssuePkg::ALU_ADD, 15, 12, 0, 32'd4, 0, 0);
        setSlot(1, 6, KindL, dualIssuePkg::ALU_ADD, 6, 2, 0, $random(seed), 0, 0);
        setSlot(2, 6, KindR, dualIssuePkg::ALU_AND, 16, 14, 13, 32'd0, 1, 0);
        setSlot(1, 7, KindI, dualIssuePkg::ALU_ADD, 7, 0, 0, 32'd5, 0, 0);
        setSlot(2, 7, KindI, dualIssuePkg::ALU_ADD, 7, 0, 0, 32'd9, 0, 0);
        setSlot(1, 8, KindI, dualIssuePkg::ALU_ADD, 0, 1, 0, 32'd1, 0, 0);
        setSlot(1, 9, KindI, dualIssuePkg::ALU_ADD, 8, 0, 0, 32'd1, 0, 0);
        tbl[1][9].fd = 1'b1;
        setSlot(2, 9, KindI, dualIssuePkg::ALU_ADD, 17, 0, 0, 32'd1, 0, 0);
        tbl[2][9].fe = 1'b1;
        setSlot(1, 10, KindI, dualIssuePkg::ALU_ADD, 9, 0, 0, 32'd3, 0, 0);
        setSlot(1, 11, KindI, dualIssuePkg::ALU_ADD, 8, 0, 0, 32'd2, 0, 0);
        tbl[1][11].st = 1'b1;
        setSlot(2, 11, KindI, dualIssuePkg::ALU_ADD, 18, 0, 0, 32'd2, 0, 0);
        setSlot(1, 15, KindR, dualIssuePkg::ALU_ADD, 1, 7, 0, 32'd0, 0, 0);
        setSlot(2, 15, KindR, dualIssuePkg::ALU_ADD, 19, 9, 0, 32'd0, 0, 0);
        setSlot(1, 16, KindR, dualIssuePkg::ALU_ADD, 2, 17, 0, 32'd0, 0, 0);
        setSlot(2, 16, KindR, dualIssuePkg::ALU_ADD, 20, 0, 8, 32'd0, 0, 0);

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < NumRows; r++) begin
            @(posedge clk);
            driveRow(1, r, cycleNo + 1);
            driveRow(2, r, cycleNo + 1);
        end
        while (wbQ[1].size() > 0 || wbQ[2].size() > 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
src/dualIssuePkg.sv
src/laneDecode.sv
src/laneExecute.sv
src/laneRetire.sv
src/regFile.sv
src/dualIssueDatapath.sv
dv/tbDualIssue.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tbDualIssue
FILELIST  := sources.f
FLAGS     := --binary --timing -Wno-fatal
OBJDIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
